/* list.f */
logic/exe_pkg.sv
logic/alu_logic_shift.sv
logic/alu_arith.sv
logic/mul_unit.sv
logic/hilo_file.sv
logic/ex_writeback_reg.sv
logic/ex_stage.sv
testbench/tb_clock.sv
testbench/ex_properties.sv
testbench/ex_checker.sv
testbench/tb_ex_stage.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ex_stage
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/tb_ex_stage.sv */
`default_nettype none

module tb_ex_stage;
    import exe_pkg::*;

    localparam int N_RAND    = 40;
    localparam int TOTAL_OPS = 4 * N_RAND + 60;
    localparam int MARGIN    = 20;

    localparam aluop_t LS_OPS [7] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA};
    localparam aluop_t AR_OPS [8] = '{OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
                                      OP_SUB, OP_SUBU, OP_SLT, OP_SLTU};
    localparam word_t  MUL_A [5]  = '{32'hffff_fffd, 32'h0000_0007, 32'hffff_fffb,
                                      32'h8000_0000, 32'hffff_ffff};
    localparam word_t  MUL_B [5]  = '{32'h0000_0007, 32'hffff_fffd, 32'hffff_fff7,
                                      32'h8000_0000, 32'hffff_ffff};

    logic        clk;
    logic        reset_i;
    aluop_t      aluop;
    alusel_t     alusel;
    word_t       reg1;
    word_t       reg2;
    reg_addr_t   wd;
    logic        wreg;
    reg_addr_t   wd_o;
    logic        wreg_o;
    word_t       wdata_o;
    logic        whilo_o;
    word_t       hi_o;
    word_t       lo_o;
    int          errors;
    int          checks;
    int          err_mark = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_state = 32'h6e50_b80c;

    tb_clock u_clock (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    ex_stage u_dut (
        .clk     (clk),
        .reset_i (reset_i),
        .aluop_i (aluop),
        .alusel_i(alusel),
        .reg1_i  (reg1),
        .reg2_i  (reg2),
        .wd_i    (wd),
        .wreg_i  (wreg),
        .wd_o    (wd_o),
        .wreg_o  (wreg_o),
        .wdata_o (wdata_o),
        .whilo_o (whilo_o),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

    ex_checker u_chk (
        .clk_i       (clk),
        .reset_i     (reset_i),
        .aluop_i     (aluop),
        .alusel_i    (alusel),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .wd_i        (wd),
        .wreg_i      (wreg),
        .dut_wd_i    (wd_o),
        .dut_wreg_i  (wreg_o),
        .dut_wdata_i (wdata_o),
        .dut_whilo_i (whilo_o),
        .dut_hi_i    (hi_o),
        .dut_lo_i    (lo_o),
        .errors_o    (errors),
        .checks_o    (checks)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output word_t value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[WORD_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic issue(input aluop_t op, input alusel_t sel, input word_t r1,
                         input word_t r2, input logic we);
        word_t dest;
        take_random(5, dest);
        @(posedge clk);
        #1;
        aluop  = op;
        alusel = sel;
        reg1   = r1;
        reg2   = r2;
        wd     = dest[4:0];
        wreg   = we;
    endtask

    // two bubbles carry the last result past the checker
    task automatic end_test(input string name);
        issue(OP_NOP, SEL_NOP, '0, '0, 1'b0);
        issue(OP_NOP, SEL_NOP, '0, '0, 1'b0);
        if (errors != err_mark) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %-12s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        #((TOTAL_OPS + MARGIN) * 10);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 TOTAL_OPS + MARGIN);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        word_t a;
        word_t b;
        word_t c;
        aluop  = OP_NOP;
        alusel = SEL_NOP;
        reg1   = '0;
        reg2   = '0;
        wd     = '0;
        wreg   = 1'b0;
        @(negedge reset_i);

        repeat (4) issue(OP_NOP, SEL_NOP, '0, '0, 1'b0);
        issue(OP_MFHI, SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MFLO, SEL_MOVE, '0, '0, 1'b1);
        end_test("reset_nop");

        for (int i = 0; i < N_RAND; i++) begin
            take_random(32, a);
            take_random(32, b);
            issue(LS_OPS[i % 7], (i % 7 < 4) ? SEL_LOGIC : SEL_SHIFT, a, b, 1'b1);
        end
        issue(OP_SLL, SEL_SHIFT, 32'hffff_ffe0, 32'h8765_4321, 1'b1);
        issue(OP_SRL, SEL_SHIFT, 32'hffff_ffe0, 32'h8765_4321, 1'b1);
        issue(OP_SRA, SEL_SHIFT, 32'hffff_ffe0, 32'h8765_4321, 1'b1);
        issue(OP_SLL, SEL_SHIFT, 32'h0000_001f, 32'h8765_4321, 1'b1);
        issue(OP_SRL, SEL_SHIFT, 32'h0000_001f, 32'h8765_4321, 1'b1);
        issue(OP_SRA, SEL_SHIFT, 32'h0000_001f, 32'h8765_4321, 1'b1);
        end_test("logic_shift");

        for (int i = 0; i < N_RAND; i++) begin
            take_random(32, a);
            take_random(32, b);
            issue(AR_OPS[i % 8], SEL_ARITH, a, b, 1'b1);
        end
        issue(OP_ADD,  SEL_ARITH, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
        issue(OP_ADDI, SEL_ARITH, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
        issue(OP_ADDU, SEL_ARITH, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
        issue(OP_ADD,  SEL_ARITH, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        issue(OP_SUB,  SEL_ARITH, 32'h8000_0000, 32'h0000_0001, 1'b1);
        issue(OP_SUBU, SEL_ARITH, 32'h8000_0000, 32'h0000_0001, 1'b1);
        issue(OP_SUB,  SEL_ARITH, 32'h0000_0000, 32'h8000_0000, 1'b1);
        issue(OP_SLT,  SEL_ARITH, 32'h8000_0000, 32'h0000_0001, 1'b1);
        issue(OP_SLT,  SEL_ARITH, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);
        issue(OP_SLT,  SEL_ARITH, 32'h0000_0000, 32'h8000_0000, 1'b1);
        issue(OP_SLTU, SEL_ARITH, 32'h0000_0001, 32'hffff_ffff, 1'b1);
        issue(OP_CLZ, SEL_ARITH, 32'h0000_0000, '0, 1'b1);
        issue(OP_CLZ, SEL_ARITH, 32'hffff_ffff, '0, 1'b1);
        issue(OP_CLO, SEL_ARITH, 32'h0000_0000, '0, 1'b1);
        issue(OP_CLO, SEL_ARITH, 32'hffff_ffff, '0, 1'b1);
        for (int k = 0; k < WORD_W; k += 5) begin
            issue(OP_CLZ, SEL_ARITH, word_t'(1) << k, '0, 1'b1);
            issue(OP_CLO, SEL_ARITH, ~(word_t'(1) << k), '0, 1'b1);
        end
        issue(OP_CLZ, SEL_ARITH, 32'h8000_0000, '0, 1'b1);
        issue(OP_CLO, SEL_ARITH, 32'h7fff_ffff, '0, 1'b1);
        end_test("arith");

        for (int i = 0; i < 5; i++) begin
            issue(OP_MUL,   SEL_MUL, MUL_A[i], MUL_B[i], 1'b1);
            issue(OP_MULT,  SEL_NOP, MUL_A[i], MUL_B[i], 1'b0);
            issue(OP_MULTU, SEL_NOP, MUL_A[i], MUL_B[i], 1'b0);
        end
        for (int i = 0; i < N_RAND / 4; i++) begin
            take_random(32, a);
            take_random(32, b);
            issue(OP_MUL,   SEL_MUL, a, b, 1'b1);
            issue(OP_MULT,  SEL_NOP, a, b, 1'b0);
            issue(OP_MULTU, SEL_NOP, a, b, 1'b0);
        end
        end_test("multiply");

        take_random(32, a);
        take_random(32, b);
        take_random(32, c);
        issue(OP_MTHI,  SEL_NOP,  a, '0, 1'b0);
        issue(OP_MFHI,  SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MULT,  SEL_NOP,  a, b, 1'b0);
        issue(OP_MFLO,  SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MFHI,  SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MTLO,  SEL_NOP,  c, '0, 1'b0);
        issue(OP_MFHI,  SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MFLO,  SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MULTU, SEL_NOP,  b, c, 1'b0);
        issue(OP_MTHI,  SEL_NOP,  c, '0, 1'b0);
        issue(OP_MFLO,  SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MFHI,  SEL_MOVE, '0, '0, 1'b1);
        // mtlo right behind mult keeps the pending HI
        issue(OP_MULT,  SEL_NOP,  c, a, 1'b0);
        issue(OP_MTLO,  SEL_NOP,  b, '0, 1'b0);
        issue(OP_MFHI,  SEL_MOVE, '0, '0, 1'b1);
        issue(OP_MFLO,  SEL_MOVE, '0, '0, 1'b1);
        end_test("hilo_fwd");

        $display("%0d tests failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_failed, checks, errors, u_dut.u_props.fail_count);
        if (tests_failed == 0 && errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/ex_checker.sv */
`default_nettype none

module ex_checker (
    input  wire                clk_i,
    input  wire                reset_i,
    input  exe_pkg::aluop_t    aluop_i,
    input  exe_pkg::alusel_t   alusel_i,
    input  exe_pkg::word_t     reg1_i,
    input  exe_pkg::word_t     reg2_i,
    input  exe_pkg::reg_addr_t wd_i,
    input  wire                wreg_i,
    input  exe_pkg::reg_addr_t dut_wd_i,
    input  wire                dut_wreg_i,
    input  exe_pkg::word_t     dut_wdata_i,
    input  wire                dut_whilo_i,
    input  exe_pkg::word_t     dut_hi_i,
    input  exe_pkg::word_t     dut_lo_i,
    output int                 errors_o,
    output int                 checks_o
);
    import exe_pkg::*;

    int        err_cnt = 0;
    int        chk_cnt = 0;
    logic      exp_valid = 1'b0;
    word_t     model_hi = '0;
    word_t     model_lo = '0;
    reg_addr_t exp_wd;
    logic      exp_wreg;
    word_t     exp_wdata;
    logic      exp_whilo;
    word_t     exp_hi;
    word_t     exp_lo;

    assign errors_o = err_cnt;
    assign checks_o = chk_cnt;

    function automatic word_t leading_count(word_t w, logic bit_val);
        word_t n;
        logic  run;
        n   = '0;
        run = 1'b1;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            run = run && (w[i] == bit_val);
            if (run) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    function automatic void predict(
        input  aluop_t  op,
        input  alusel_t sel,
        input  word_t   r1,
        input  word_t   r2,
        input  logic    we,
        output logic    wreg_e,
        output word_t   wdata_e,
        output logic    whilo_e,
        output word_t   hi_e,
        output word_t   lo_e
    );
        logic [WORD_W:0]    sum_x;
        logic [WORD_W:0]    diff_x;
        dword_t             prod;
        word_t              res;
        logic               trap;
        logic [SHAMT_W-1:0] sh;

        sh     = r1[SHAMT_W-1:0];
        sum_x  = {r1[WORD_W-1], r1} + {r2[WORD_W-1], r2};
        diff_x = {r1[WORD_W-1], r1} - {r2[WORD_W-1], r2};
        // low half of the sign-extended product is the signed product
        if (op == OP_MUL || op == OP_MULT) begin
            prod = {{WORD_W{r1[WORD_W-1]}}, r1} * {{WORD_W{r2[WORD_W-1]}}, r2};
        end else if (op == OP_MULTU) begin
            prod = {{WORD_W{1'b0}}, r1} * {{WORD_W{1'b0}}, r2};
        end else begin
            prod = '0;
        end

        res = '0;
        if (sel == SEL_LOGIC) begin
            case (op)
                OP_AND:  res = r1 & r2;
                OP_OR:   res = r1 | r2;
                OP_XOR:  res = r1 ^ r2;
                OP_NOR:  res = ~(r1 | r2);
                default: res = '0;
            endcase
        end else if (sel == SEL_SHIFT) begin
            case (op)
                OP_SLL:  res = r2 << r1[SHAMT_W-1:0];
                OP_SRL:  res = r2 >> r1[SHAMT_W-1:0];
                // logical shift with the vacated top bits filled by the sign
                OP_SRA:  res = (r2 >> sh) | ({WORD_W{r2[WORD_W-1]}} & ~({WORD_W{1'b1}} >> sh));
                default: res = '0;
            endcase
        end else if (sel == SEL_ARITH) begin
            case (op)
                OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU: res = sum_x[WORD_W-1:0];
                OP_SUB, OP_SUBU: res = diff_x[WORD_W-1:0];
                OP_SLT:  res = word_t'($signed(r1) < $signed(r2));
                OP_SLTU: res = word_t'(r1 < r2);
                OP_CLZ:  res = leading_count(r1, 1'b0);
                OP_CLO:  res = leading_count(r1, 1'b1);
                default: res = '0;
            endcase
        end else if (sel == SEL_MOVE) begin
            res = (op == OP_MFHI) ? model_hi : (op == OP_MFLO) ? model_lo : '0;
        end else if (sel == SEL_MUL) begin
            res = prod[WORD_W-1:0];
        end

        trap = ((op == OP_ADD || op == OP_ADDI) && (sum_x[WORD_W] != sum_x[WORD_W-1])) ||
               ((op == OP_SUB) && (diff_x[WORD_W] != diff_x[WORD_W-1]));
        wreg_e  = we && !trap;
        wdata_e = res;

        whilo_e = 1'b1;
        case (op)
            OP_MTHI:           {hi_e, lo_e} = {r1, model_lo};
            OP_MTLO:           {hi_e, lo_e} = {model_hi, r1};
            OP_MULT, OP_MULTU: {hi_e, lo_e} = prod;
            default: begin
                whilo_e      = 1'b0;
                {hi_e, lo_e} = '0;
            end
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        chk_cnt = chk_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk_i) begin
        if (exp_valid) begin
            check_value("wd_o", word_t'(dut_wd_i), word_t'(exp_wd));
            check_value("wreg_o", word_t'(dut_wreg_i), word_t'(exp_wreg));
            check_value("wdata_o", dut_wdata_i, exp_wdata);
            check_value("whilo_o", word_t'(dut_whilo_i), word_t'(exp_whilo));
            check_value("hi_o", dut_hi_i, exp_hi);
            check_value("lo_o", dut_lo_i, exp_lo);
        end
        if (reset_i !== 1'b0) begin
            model_hi  = '0;
            model_lo  = '0;
            exp_wd    = '0;
            exp_wreg  = 1'b0;
            exp_wdata = '0;
            exp_whilo = 1'b0;
            exp_hi    = '0;
            exp_lo    = '0;
        end else begin
            exp_wd = wd_i;
            predict(aluop_i, alusel_i, reg1_i, reg2_i, wreg_i,
                    exp_wreg, exp_wdata, exp_whilo, exp_hi, exp_lo);
            // newest hi/lo is visible to the very next operation
            if (exp_whilo) begin
                model_hi = exp_hi;
                model_lo = exp_lo;
            end
        end
        exp_valid = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/ex_properties.sv */
`default_nettype none

module ex_properties (
    input wire             clk_i,
    input wire             reset_i,
    input exe_pkg::aluop_t aluop_i,
    input wire             dut_wreg_i,
    input wire             dut_whilo_i
);
    import exe_pkg::*;

    int   fail_count = 0;
    logic hilo_write;

    assign hilo_write = (aluop_i == OP_MTHI) || (aluop_i == OP_MTLO) ||
                        (aluop_i == OP_MULT) || (aluop_i == OP_MULTU);

    reset_clears_writes: assert property (@(posedge clk_i)
        reset_i |=> !dut_wreg_i && !dut_whilo_i)
        else begin
            fail_count++;
            $error("write enable high in the cycle after reset");
        end

    hilo_write_follows: assert property (@(posedge clk_i) disable iff (reset_i)
        hilo_write |=> dut_whilo_i)
        else begin
            fail_count++;
            $error("whilo_o missing after a HI/LO write operation");
        end

    // and no spurious hi/lo write
    hilo_write_only: assert property (@(posedge clk_i) disable iff (reset_i)
        !hilo_write |=> !dut_whilo_i)
        else begin
            fail_count++;
            $error("whilo_o high without a HI/LO write operation");
        end

    nop_no_write: assert property (@(posedge clk_i) disable iff (reset_i)
        (aluop_i == OP_NOP) |=> !dut_wreg_i)
        else begin
            fail_count++;
            $error("wreg_o high after a nop");
        end

endmodule

bind ex_stage ex_properties u_props (
    .clk_i       (clk),
    .reset_i     (reset_i),
    .aluop_i     (aluop_i),
    .dut_wreg_i  (wreg_o),
    .dut_whilo_i (whilo_o)
);

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // held over four rising edges
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/ex_stage.sv */
`default_nettype none

module ex_stage (
    input  wire                clk,
    input  wire                reset_i,
    input  exe_pkg::aluop_t    aluop_i,
    input  exe_pkg::alusel_t   alusel_i,
    input  exe_pkg::word_t     reg1_i,
    input  exe_pkg::word_t     reg2_i,
    input  exe_pkg::reg_addr_t wd_i,
    input  wire                wreg_i,
    output exe_pkg::reg_addr_t wd_o,
    output logic               wreg_o,
    output exe_pkg::word_t     wdata_o,
    output logic               whilo_o,
    output exe_pkg::word_t     hi_o,
    output exe_pkg::word_t     lo_o
);
    import exe_pkg::*;

    word_t  logic_res;
    word_t  shift_res;
    word_t  arith_res;
    logic   overflow;
    dword_t product;
    word_t  hi_cur;
    word_t  lo_cur;

    alu_logic_shift u_logic_shift (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res)
    );

    alu_arith u_arith (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .arith_res_o (arith_res),
        .overflow_o  (overflow)
    );

    mul_unit u_mul (
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .product_o (product)
    );

    // registered hi/lo write feeds back as the pending write
    hilo_file u_hilo (
        .clk      (clk),
        .reset_i  (reset_i),
        .whilo_i  (whilo_o),
        .hi_i     (hi_o),
        .lo_i     (lo_o),
        .hi_cur_o (hi_cur),
        .lo_cur_o (lo_cur)
    );

    ex_writeback_reg u_wb (
        .clk         (clk),
        .reset_i     (reset_i),
        .aluop_i     (aluop_i),
        .alusel_i    (alusel_i),
        .reg1_i      (reg1_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .logic_res_i (logic_res),
        .shift_res_i (shift_res),
        .arith_res_i (arith_res),
        .overflow_i  (overflow),
        .product_i   (product),
        .hi_cur_i    (hi_cur),
        .lo_cur_i    (lo_cur),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .whilo_o     (whilo_o),
        .hi_o        (hi_o),
        .lo_o        (lo_o)
    );

endmodule

`default_nettype wire

/* logic/ex_writeback_reg.sv */
`default_nettype none

module ex_writeback_reg (
    input  wire                clk,
    input  wire                reset_i,
    input  exe_pkg::aluop_t    aluop_i,
    input  exe_pkg::alusel_t   alusel_i,
    input  exe_pkg::word_t     reg1_i,
    input  exe_pkg::reg_addr_t wd_i,
    input  wire                wreg_i,
    input  exe_pkg::word_t     logic_res_i,
    input  exe_pkg::word_t     shift_res_i,
    input  exe_pkg::word_t     arith_res_i,
    input  wire                overflow_i,
    input  exe_pkg::dword_t    product_i,
    input  exe_pkg::word_t     hi_cur_i,
    input  exe_pkg::word_t     lo_cur_i,
    output exe_pkg::reg_addr_t wd_o,
    output logic               wreg_o,
    output exe_pkg::word_t     wdata_o,
    output logic               whilo_o,
    output exe_pkg::word_t     hi_o,
    output exe_pkg::word_t     lo_o
);
    import exe_pkg::*;

    word_t move_res;
    word_t wdata_d;
    logic  wreg_d;
    logic  whilo_d;
    word_t hi_d;
    word_t lo_d;

    assign move_res = (aluop_i == OP_MFHI) ? hi_cur_i :
                      (aluop_i == OP_MFLO) ? lo_cur_i : '0;

    always_comb begin
        case (alusel_i)
            SEL_LOGIC: wdata_d = logic_res_i;
            SEL_SHIFT: wdata_d = shift_res_i;
            SEL_MOVE:  wdata_d = move_res;
            SEL_ARITH: wdata_d = arith_res_i;
            SEL_MUL:   wdata_d = product_i[WORD_W-1:0];
            default:   wdata_d = '0;
        endcase
    end

    // trapping ops drop the write on signed overflow
    assign wreg_d = wreg_i && !(overflow_i &&
                    ((aluop_i == OP_ADD) || (aluop_i == OP_ADDI) || (aluop_i == OP_SUB)));

    always_comb begin
        whilo_d = 1'b1;
        case (aluop_i)
            OP_MTHI:           {hi_d, lo_d} = {reg1_i, lo_cur_i};
            OP_MTLO:           {hi_d, lo_d} = {hi_cur_i, reg1_i};
            OP_MULT, OP_MULTU: {hi_d, lo_d} = product_i;
            default: begin
                whilo_d      = 1'b0;
                {hi_d, lo_d} = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wd_o    <= '0;
            wreg_o  <= 1'b0;
            wdata_o <= '0;
            whilo_o <= 1'b0;
            hi_o    <= '0;
            lo_o    <= '0;
        end else begin
            wd_o    <= wd_i;
            wreg_o  <= wreg_d;
            wdata_o <= wdata_d;
            whilo_o <= whilo_d;
            hi_o    <= hi_d;
            lo_o    <= lo_d;
        end
    end

endmodule

`default_nettype wire

/* logic/hilo_file.sv */
`default_nettype none

module hilo_file (
    input  wire            clk,
    input  wire            reset_i,
    input  wire            whilo_i,
    input  exe_pkg::word_t hi_i,
    input  exe_pkg::word_t lo_i,
    output exe_pkg::word_t hi_cur_o,
    output exe_pkg::word_t lo_cur_o
);
    import exe_pkg::*;

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (whilo_i) begin
            hi_q <= hi_i;
            lo_q <= lo_i;
        end
    end

    // pending write wins over the stored pair
    assign hi_cur_o = whilo_i ? hi_i : hi_q;
    assign lo_cur_o = whilo_i ? lo_i : lo_q;

endmodule

`default_nettype wire

/* logic/mul_unit.sv */
`default_nettype none

module mul_unit (
    input  exe_pkg::aluop_t aluop_i,
    input  exe_pkg::word_t  reg1_i,
    input  exe_pkg::word_t  reg2_i,
    output exe_pkg::dword_t product_o
);
    import exe_pkg::*;

    logic   is_signed;
    word_t  op1_mag;
    word_t  op2_mag;
    dword_t raw;

    assign is_signed = (aluop_i == OP_MUL) || (aluop_i == OP_MULT);

    // signed multiply works on magnitudes, sign fixed afterwards
    assign op1_mag = (is_signed && reg1_i[WORD_W-1]) ? (~reg1_i) + 1'b1 : reg1_i;
    assign op2_mag = (is_signed && reg2_i[WORD_W-1]) ? (~reg2_i) + 1'b1 : reg2_i;
    assign raw     = dword_t'(op1_mag) * dword_t'(op2_mag);

    always_comb begin
        if (is_signed) begin
            product_o = (reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1]) ? (~raw) + 1'b1 : raw;
        end else if (aluop_i == OP_MULTU) begin
            product_o = raw;
        end else begin
            product_o = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/alu_arith.sv */
`default_nettype none

module alu_arith (
    input  exe_pkg::aluop_t aluop_i,
    input  exe_pkg::word_t  reg1_i,
    input  exe_pkg::word_t  reg2_i,
    output exe_pkg::word_t  arith_res_o,
    output logic            overflow_o
);
    import exe_pkg::*;

    word_t reg2_com;
    word_t sum;
    logic  is_sub;
    logic  reg1_lt_reg2;

    // position of the first set bit from the top, WORD_W when none
    function automatic word_t lead_zeros(word_t w);
        word_t cnt;
        logic  found;
        cnt   = word_t'(WORD_W);
        found = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (!found && w[i]) begin
                cnt   = word_t'(WORD_W - 1 - i);
                found = 1'b1;
            end
        end
        return cnt;
    endfunction

    assign is_sub   = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU) || (aluop_i == OP_SLT);
    assign reg2_com = is_sub ? (~reg2_i) + 1'b1 : reg2_i;
    assign sum      = reg1_i + reg2_com;

    // same operand signs, different result sign
    // second operand sign taken from reg2, inverted for a subtract
    assign overflow_o = (reg1_i[WORD_W-1] == (reg2_i[WORD_W-1] ^ is_sub)) &&
                        (sum[WORD_W-1] != reg1_i[WORD_W-1]);

    assign reg1_lt_reg2 = (aluop_i == OP_SLT) ? (overflow_o ? !sum[WORD_W-1] : sum[WORD_W-1])
                                              : (reg1_i < reg2_i);

    always_comb begin
        case (aluop_i)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU: begin
                arith_res_o = sum;
            end
            OP_SLT, OP_SLTU: begin
                arith_res_o = word_t'(reg1_lt_reg2);
            end
            OP_CLZ: begin
                arith_res_o = lead_zeros(reg1_i);
            end
            OP_CLO: begin
                arith_res_o = lead_zeros(~reg1_i);
            end
            default: begin
                arith_res_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/alu_logic_shift.sv */
`default_nettype none

module alu_logic_shift (
    input  exe_pkg::aluop_t aluop_i,
    input  exe_pkg::word_t  reg1_i,
    input  exe_pkg::word_t  reg2_i,
    output exe_pkg::word_t  logic_res_o,
    output exe_pkg::word_t  shift_res_o
);
    import exe_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = reg1_i[SHAMT_W-1:0];

    always_comb begin
        case (aluop_i)
            OP_AND:  logic_res_o = reg1_i & reg2_i;
            OP_OR:   logic_res_o = reg1_i | reg2_i;
            OP_XOR:  logic_res_o = reg1_i ^ reg2_i;
            OP_NOR:  logic_res_o = ~(reg1_i | reg2_i);
            default: logic_res_o = '0;
        endcase
    end

    // shift reg2 by the low bits of reg1
    always_comb begin
        case (aluop_i)
            OP_SLL:  shift_res_o = reg2_i << shamt;
            OP_SRL:  shift_res_o = reg2_i >> shamt;
            OP_SRA:  shift_res_o = word_t'($signed(reg2_i) >>> shamt);
            default: shift_res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    localparam int WORD_W  = 32;
    localparam int SHAMT_W = 5;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [2*WORD_W-1:0] dword_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [7:0]          aluop_t;
    typedef logic [2:0]          alusel_t;

    // operation codes, bubble is zero
    localparam aluop_t OP_NOP   = 8'b0000_0000;

    localparam aluop_t OP_AND   = 8'b0010_0100;
    localparam aluop_t OP_OR    = 8'b0010_0101;
    localparam aluop_t OP_XOR   = 8'b0010_0110;
    localparam aluop_t OP_NOR   = 8'b0010_0111;

    localparam aluop_t OP_SLL   = 8'b0111_1100;
    localparam aluop_t OP_SRL   = 8'b0000_0010;
    localparam aluop_t OP_SRA   = 8'b0000_0011;

    localparam aluop_t OP_ADD   = 8'b0010_0000;
    localparam aluop_t OP_ADDU  = 8'b0010_0001;
    localparam aluop_t OP_ADDI  = 8'b0101_0101;
    localparam aluop_t OP_ADDIU = 8'b0101_0110;
    localparam aluop_t OP_SUB   = 8'b0010_0010;
    localparam aluop_t OP_SUBU  = 8'b0010_0011;
    localparam aluop_t OP_SLT   = 8'b0010_1010;
    localparam aluop_t OP_SLTU  = 8'b0010_1011;
    localparam aluop_t OP_CLZ   = 8'b1011_0000;
    localparam aluop_t OP_CLO   = 8'b1011_0001;

    // hi/lo moves
    localparam aluop_t OP_MFHI  = 8'b0001_0000;
    localparam aluop_t OP_MTHI  = 8'b0001_0001;
    localparam aluop_t OP_MFLO  = 8'b0001_0010;
    localparam aluop_t OP_MTLO  = 8'b0001_0011;

    localparam aluop_t OP_MUL   = 8'b1010_1001;
    localparam aluop_t OP_MULT  = 8'b0001_1000;
    localparam aluop_t OP_MULTU = 8'b0001_1001;

    // result groups
    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;
    localparam alusel_t SEL_MOVE  = 3'b011;
    localparam alusel_t SEL_ARITH = 3'b100;
    localparam alusel_t SEL_MUL   = 3'b101;

endpackage

`default_nettype wire
